// File: design/capture_pkg.sv
package capture_pkg;

    // Sample and lane geometry
    localparam int SAMPLE_WIDTH     = 32;
    localparam int LANE_WIDTH       = 16;
    localparam int LANES_PER_SAMPLE = SAMPLE_WIDTH / LANE_WIDTH;
    localparam int LANE_CNT_WIDTH   = 1;

    // Ring geometry
    localparam int RING_DEPTH       = 64;
    localparam int ADDR_WIDTH       = 6;

    // Samples kept ahead of the trigger edge
    localparam int PRE_TRIGGER_LEN  = 8;

    typedef enum logic [1:0]
    {
        ST_RECORD = 2'b00,
        ST_POST   = 2'b01,
        ST_HOLD   = 2'b10,
        ST_DRAIN  = 2'b11
    } capture_state_t;

endpackage

// File: design/ring_memory.sv
`timescale 1ns/100ps

module ring_memory
    import capture_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic [SAMPLE_WIDTH-1:0] din,
    input  logic                    mem_we,
    input  logic                    mem_re,
    input  logic [ADDR_WIDTH-1:0]   mem_raddr,
    output logic [ADDR_WIDTH-1:0]   wr_ptr,
    output logic [SAMPLE_WIDTH-1:0] rd_data
);

    logic [SAMPLE_WIDTH-1:0] mem [RING_DEPTH];
    logic [ADDR_WIDTH-1:0]   wr_ptr_q;
    logic [ADDR_WIDTH-1:0]   wr_ptr_next;
    logic [SAMPLE_WIDTH-1:0] rd_data_q;

    // Wrap explicitly so the depth need not be a power of two
    always_comb
    begin
        if (wr_ptr_q == ADDR_WIDTH'(RING_DEPTH - 1))
        begin
            wr_ptr_next = '0;
        end
        else
        begin
            wr_ptr_next = wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            wr_ptr_q <= '0;
        end
        else if (mem_we)
        begin
            wr_ptr_q <= wr_ptr_next;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (mem_we)
        begin
            mem[wr_ptr_q] <= din;
        end
    end

    // Registered read port, data follows mem_re by one cycle
    always_ff @(posedge CLK)
    begin
        if (mem_re)
        begin
            rd_data_q <= mem[mem_raddr];
        end
    end

    assign wr_ptr  = wr_ptr_q;
    assign rd_data = rd_data_q;

endmodule

// File: design/lane_serializer.sv
`timescale 1ns/100ps

module lane_serializer
    import capture_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic [SAMPLE_WIDTH-1:0] rd_data,
    input  logic                    ser_load,
    input  logic                    ser_last,
    output logic [LANE_WIDTH-1:0]   dout,
    output logic                    dout_valid,
    output logic                    dout_done,
    output logic                    lane_last
);

    logic [SAMPLE_WIDTH-1:0]   word_q;
    logic [LANE_CNT_WIDTH-1:0] lane_cnt;
    logic                      last_q;
    logic                      active;

    logic [SAMPLE_WIDTH-1:0]   cur_word;
    logic [LANE_CNT_WIDTH-1:0] cur_lane;
    logic                      cur_last;

    // Lane 0 comes straight from the read port in the load cycle
    always_comb
    begin
        if (ser_load)
        begin
            cur_word = rd_data;
            cur_lane = '0;
            cur_last = ser_last;
        end
        else
        begin
            cur_word = word_q;
            cur_lane = lane_cnt;
            cur_last = last_q;
        end
    end

    assign dout       = cur_word[LANE_WIDTH-1:0];
    assign dout_valid = ser_load | active;
    assign lane_last  = dout_valid & (cur_lane == LANE_CNT_WIDTH'(LANES_PER_SAMPLE - 1));

    // An end marker without a word closes an empty window
    assign dout_done  = (lane_last & cur_last) | (ser_last & !ser_load);

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            active   <= 1'b0;
            lane_cnt <= '0;
            last_q   <= 1'b0;
        end
        else if (dout_valid)
        begin
            if (lane_last)
            begin
                active <= 1'b0;
            end
            else
            begin
                active   <= 1'b1;
                lane_cnt <= cur_lane + 1'b1;
                last_q   <= cur_last;
            end
        end
    end

    // Shift the remaining lanes down, low lane first
    always_ff @(posedge CLK)
    begin
        if (dout_valid && !lane_last)
        begin
            word_q <= cur_word >> LANE_WIDTH;
        end
    end

endmodule

// File: design/capture_ctrl.sv
`timescale 1ns/100ps

module capture_ctrl
    import capture_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr_en,
    input  logic                  trigger,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] wr_ptr,
    input  logic                  lane_last,
    output logic                  mem_we,
    output logic                  mem_re,
    output logic [ADDR_WIDTH-1:0] mem_raddr,
    output logic                  ser_load,
    output logic                  ser_last,
    output logic                  full,
    output logic                  empty
);

    capture_state_t        state;
    logic                  trig_q;
    logic [ADDR_WIDTH:0]   fill;
    logic [ADDR_WIDTH-1:0] win_start;
    logic [ADDR_WIDTH-1:0] win_end;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic                  busy;
    logic                  kick;

    logic                  trig_rise;
    logic                  trig_fall;
    logic [ADDR_WIDTH-1:0] next_wr;
    logic [ADDR_WIDTH-1:0] next_rd;
    logic [ADDR_WIDTH-1:0] pre_cnt;
    logic                  win_empty;
    logic                  words_left;

    assign trig_rise  = trigger & !trig_q;
    assign trig_fall  = !trigger & trig_q;
    assign next_wr    = ADDR_WIDTH'((wr_ptr + 1) % RING_DEPTH);
    assign next_rd    = ADDR_WIDTH'((rd_ptr + 1) % RING_DEPTH);
    assign pre_cnt    = (fill < PRE_TRIGGER_LEN) ? fill[ADDR_WIDTH-1:0]
                                                 : ADDR_WIDTH'(PRE_TRIGGER_LEN);
    assign win_empty  = (win_start == win_end);
    assign words_left = (rd_ptr != win_end);

    // Window must not wrap onto its own first sample
    assign full   = (state == ST_POST) && (next_wr == win_start);
    assign empty  = (state == ST_RECORD) ||
                    (((state == ST_HOLD) || (state == ST_DRAIN)) && win_empty);
    assign mem_we = wr_en && ((state == ST_RECORD) ||
                              ((state == ST_POST) && !trig_fall && !full));

    // Next word goes out during the last lane of the current one
    assign mem_re    = (state == ST_DRAIN) && words_left &&
                       (kick || (rd_en && (!busy || lane_last)));
    assign mem_raddr = rd_ptr;

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            state     <= ST_RECORD;
            trig_q    <= 1'b0;
            fill      <= '0;
            win_start <= '0;
            win_end   <= '0;
            rd_ptr    <= '0;
            kick      <= 1'b0;
        end
        else
        begin
            trig_q <= trigger;
            kick   <= 1'b0;
            case (state)
                ST_RECORD:
                begin
                    if (mem_we && (fill != (ADDR_WIDTH + 1)'(RING_DEPTH)))
                    begin
                        fill <= fill + 1'b1;
                    end
                    if (trig_rise)
                    begin
                        win_start <= wr_ptr - pre_cnt;
                        state     <= ST_POST;
                    end
                end
                ST_POST:
                begin
                    if (trig_fall)
                    begin
                        win_end <= wr_ptr;
                        state   <= ST_HOLD;
                    end
                end
                ST_HOLD:
                begin
                    if (rd_en)
                    begin
                        if (win_empty)
                        begin
                            fill  <= '0;
                            state <= ST_RECORD;
                        end
                        else
                        begin
                            rd_ptr <= win_start;
                            kick   <= 1'b1;
                            state  <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN:
                begin
                    if (mem_re)
                    begin
                        rd_ptr <= next_rd;
                    end
                    // Final word's last lane, nothing left to fetch
                    if (lane_last && !words_left)
                    begin
                        fill  <= '0;
                        state <= ST_RECORD;
                    end
                end
                default:
                begin
                    state <= ST_RECORD;
                end
            endcase
        end
    end

    // Serializer strobes line up with the registered read data
    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            busy     <= 1'b0;
            ser_load <= 1'b0;
            ser_last <= 1'b0;
        end
        else
        begin
            ser_load <= mem_re;
            ser_last <= (mem_re && (next_rd == win_end)) ||
                        ((state == ST_HOLD) && rd_en && win_empty);
            if (mem_re)
            begin
                busy <= 1'b1;
            end
            else if (lane_last)
            begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: design/capture_top.sv
`timescale 1ns/100ps

module capture_top
    import capture_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic [SAMPLE_WIDTH-1:0] din,
    input  logic                    wr_en,
    input  logic                    trigger,
    input  logic                    rd_en,
    output logic [LANE_WIDTH-1:0]   dout,
    output logic                    dout_valid,
    output logic                    dout_done,
    output logic                    full,
    output logic                    empty
);

    logic                    mem_we;
    logic                    mem_re;
    logic [ADDR_WIDTH-1:0]   mem_raddr;
    logic [ADDR_WIDTH-1:0]   wr_ptr;
    logic [SAMPLE_WIDTH-1:0] rd_data;
    logic                    ser_load;
    logic                    ser_last;
    logic                    lane_last;

    capture_ctrl ctrl_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr_en     (wr_en),
        .trigger   (trigger),
        .rd_en     (rd_en),
        .wr_ptr    (wr_ptr),
        .lane_last (lane_last),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .ser_load  (ser_load),
        .ser_last  (ser_last),
        .full      (full),
        .empty     (empty)
    );

    ring_memory ring_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .din       (din),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .wr_ptr    (wr_ptr),
        .rd_data   (rd_data)
    );

    lane_serializer ser_i
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .rd_data    (rd_data),
        .ser_load   (ser_load),
        .ser_last   (ser_last),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_done  (dout_done),
        .lane_last  (lane_last)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Release between edges so the first active edge is clean
    initial
    begin
        RESET = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b1;
    end

endmodule

// File: verification/capture_tb.sv
`timescale 1ns/100ps

module capture_tb
    import capture_pkg::*;
;

    logic                    CLK;
    logic                    RESET;
    logic [SAMPLE_WIDTH-1:0] din;
    logic                    wr_en;
    logic                    trigger;
    logic                    rd_en;
    logic [LANE_WIDTH-1:0]   dout;
    logic                    dout_valid;
    logic                    dout_done;
    logic                    full;
    logic                    empty;

    // Reference model of the ring and the held window
    logic [SAMPLE_WIDTH-1:0] m_mem [RING_DEPTH];
    capture_state_t          m_state;
    int                      m_wp;
    int                      m_fill;
    int                      m_start;
    int                      m_end;
    logic                    m_trig;

    string test_name;
    int    lane_pos;
    int    last_lanes;
    int    done_count;
    logic  done_seen;
    logic  in_win;
    int    value_errs;
    int    proto_errs;
    int    timeout_errs;

    tb_clock_gen clk_gen_i
    (
        .CLK   (CLK),
        .RESET (RESET)
    );

    capture_top dut_i
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .din        (din),
        .wr_en      (wr_en),
        .trigger    (trigger),
        .rd_en      (rd_en),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_done  (dout_done),
        .full       (full),
        .empty      (empty)
    );

    function automatic int pre_count();
        return (m_fill < PRE_TRIGGER_LEN) ? m_fill : PRE_TRIGGER_LEN;
    endfunction

    function automatic int window_words();
        return (m_end - m_start + RING_DEPTH) % RING_DEPTH;
    endfunction

    function automatic logic model_full();
        return (m_state == ST_POST) && ((m_wp + 1) % RING_DEPTH == m_start);
    endfunction

    // The window end is only meaningful once the window is held
    function automatic logic model_empty();
        return (m_state == ST_RECORD) ||
               (((m_state == ST_HOLD) || (m_state == ST_DRAIN)) && (m_start == m_end));
    endfunction

    // Lanes leave low lane first, words in ring order from the window start
    function automatic logic [LANE_WIDTH-1:0] expected_lane(input int pos);
        logic [SAMPLE_WIDTH-1:0] word;
        word = m_mem[(m_start + pos / LANES_PER_SAMPLE) % RING_DEPTH];
        return word[(pos % LANES_PER_SAMPLE) * LANE_WIDTH +: LANE_WIDTH];
    endfunction

    task automatic store_sample();
        m_mem[m_wp] = din;
        m_wp = (m_wp + 1) % RING_DEPTH;
    endtask

    always @(posedge CLK)
    begin
        if (!RESET)
        begin
            m_state = ST_RECORD;
            m_wp    = 0;
            m_fill  = 0;
            m_start = 0;
            m_end   = 0;
            m_trig  = 1'b0;
        end
        else
        begin
            case (m_state)
                ST_RECORD:
                begin
                    if (trigger && !m_trig)
                    begin
                        m_start = (m_wp + RING_DEPTH - pre_count()) % RING_DEPTH;
                        m_state = ST_POST;
                    end
                    if (wr_en)
                    begin
                        store_sample();
                        if (m_fill < RING_DEPTH)
                            m_fill++;
                    end
                end
                ST_POST:
                begin
                    if (!trigger && m_trig)
                    begin
                        m_end   = m_wp;
                        m_state = ST_HOLD;
                    end
                    else if (wr_en && !model_full())
                    begin
                        store_sample();
                    end
                end
                ST_HOLD:
                begin
                    if (rd_en)
                    begin
                        m_state = (m_start == m_end) ? ST_RECORD : ST_DRAIN;
                        m_fill  = 0;
                    end
                end
                default:
                begin
                    if (done_seen)
                        m_state = ST_RECORD;
                end
            endcase
            m_trig    = trigger;
            done_seen = 1'b0;
        end
    end

    always @(negedge CLK)
    begin
        if (RESET)
        begin
            assert (full == model_full()) else
            begin
                $display("** Error [%s] full: expected %b, actual %b",
                         test_name, model_full(), full);
                value_errs++;
            end
            assert (empty == model_empty()) else
            begin
                $display("** Error [%s] empty: expected %b, actual %b",
                         test_name, model_empty(), empty);
                value_errs++;
            end
            in_win = (m_state == ST_DRAIN) && (lane_pos < window_words() * LANES_PER_SAMPLE);
            if (dout_valid)
            begin
                assert (in_win) else
                begin
                    $display("[%s] a lane came out with no window lane left to send", test_name);
                    proto_errs++;
                end
                if (in_win)
                    assert (dout == expected_lane(lane_pos)) else
                    begin
                        $display("** Error [%s] lane %0d: expected %h, actual %h",
                                 test_name, lane_pos, expected_lane(lane_pos), dout);
                        value_errs++;
                    end
                lane_pos++;
            end
            else
            begin
                assert (!(m_state == ST_DRAIN && (lane_pos % LANES_PER_SAMPLE) != 0)) else
                begin
                    $display("[%s] output paused in the middle of a word", test_name);
                    proto_errs++;
                end
            end
            if (dout_done)
            begin
                assert (lane_pos == window_words() * LANES_PER_SAMPLE) else
                begin
                    $display("** Error [%s] lanes at done: expected %0d, actual %0d",
                             test_name, window_words() * LANES_PER_SAMPLE, lane_pos);
                    value_errs++;
                end
                last_lanes = lane_pos;
                lane_pos   = 0;
                done_seen  = 1'b1;
                done_count++;
            end
        end
    end

    task automatic cycle(input logic w, input logic t, input logic r);
        @(negedge CLK);
        wr_en   = w;
        trigger = t;
        rd_en   = r;
        din     = $urandom();
    endtask

    task automatic burst(input int n, input logic t);
        repeat (n) cycle(1'b1, t, 1'b0);
    endtask

    task automatic drain(input logic toggle);
        int start_cnt;
        int n;
        start_cnt = done_count;
        n = 0;
        while (done_count == start_cnt && n < 500)
        begin
            cycle(1'b0, 1'b0, toggle ? 1'($urandom()) : 1'b1);
            n++;
        end
        if (done_count == start_cnt)
        begin
            $display("[%s] timed out waiting for dout_done after %0d cycles", test_name, n);
            timeout_errs++;
        end
        cycle(1'b0, 1'b0, 1'b0);
    endtask

    task automatic check_lane_count(input int exp_words);
        assert (last_lanes == exp_words * LANES_PER_SAMPLE) else
        begin
            $display("** Error [%s] window lanes: expected %0d, actual %0d",
                     test_name, exp_words * LANES_PER_SAMPLE, last_lanes);
            value_errs++;
        end
    endtask

    // Record, pulse the trigger, write into the held window, then read it out
    task automatic run_capture(input string name, input int pre_n, input int post_n,
                               input int hold_n, input logic toggle, input int exp_words);
        test_name = name;
        burst(pre_n, 1'b0);
        burst(post_n, 1'b1);
        cycle(1'b0, 1'b0, 1'b0);
        burst(hold_n, 1'b0);
        drain(toggle);
        check_lane_count(exp_words);
    endtask

    initial
    begin
        int n;
        void'($urandom(32'hfcd1aceb));
        din          = '0;
        wr_en        = 1'b0;
        trigger      = 1'b0;
        rd_en        = 1'b0;
        lane_pos     = 0;
        last_lanes   = 0;
        done_count   = 0;
        done_seen    = 1'b0;
        value_errs   = 0;
        proto_errs   = 0;
        timeout_errs = 0;
        test_name    = "reset";
        n = 0;
        while (!RESET && n < 20)
        begin
            @(negedge CLK);
            n++;
        end
        if (!RESET)
        begin
            $display("[reset] RESET never went high");
            timeout_errs++;
        end
        cycle(1'b0, 1'b0, 1'b0);
        assert (!dout_valid && !dout_done && !full && empty) else
        begin
            $display("** Error [reset] valid/done/full/empty: expected 0001, actual %b%b%b%b",
                     dout_valid, dout_done, full, empty);
            value_errs++;
        end
        // Read without a capture, then a trigger pulse that holds nothing
        repeat (5) cycle(1'b0, 1'b0, 1'b1);
        cycle(1'b0, 1'b1, 1'b0);
        cycle(1'b0, 1'b0, 1'b0);
        cycle(1'b0, 1'b0, 1'b0);
        drain(1'b0);
        check_lane_count(0);

        run_capture("early_trigger", 3, 4, 0, 1'b0, 7);
        run_capture("wrap_window", 100, 5, 0, 1'b0, PRE_TRIGGER_LEN + 5);
        // Writes in hold would reach the first window word of a full window
        run_capture("full_window", 20, 70, 5, 1'b0, RING_DEPTH - 1);
        run_capture("rd_en_toggle", 30, 6, 5, 1'b1, PRE_TRIGGER_LEN + 6);
        run_capture("resume", 12, 3, 0, 1'b0, PRE_TRIGGER_LEN + 3);
        repeat (4) cycle(1'b0, 1'b0, 1'b0);

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errs, proto_errs, timeout_errs);
        if (value_errs + proto_errs + timeout_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: capture.f
design/capture_pkg.sv
design/ring_memory.sv
design/lane_serializer.sv
design/capture_ctrl.sv
design/capture_top.sv
verification/tb_clock_gen.sv
verification/capture_tb.sv

// File: Bender.yml
package:
  name: capture

sources:
  - design/capture_pkg.sv
  - design/ring_memory.sv
  - design/lane_serializer.sv
  - design/capture_ctrl.sv
  - design/capture_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/capture_tb.sv
